// ==== design/gb_irq_cfg.svh ====
`ifndef GB_IRQ_CFG_SVH
`define GB_IRQ_CFG_SVH

// Interrupt sources handled by the unit
// VBLANK, LCDC, TIMA, SERIAL, HILO
`define GB_IRQ_COUNT 5

// Restart address of source 0
`define GB_IRQ_VECTOR_BASE 8'h40

// Spacing between consecutive restart addresses
// Source n jumps to base + n * step
`define GB_IRQ_VECTOR_STEP 8'h08

`endif

// ==== design/gb_irq_pkg.sv ====
`include "gb_irq_cfg.svh"

package gb_irq_pkg;

   // One flag bit per source, bit index equals source number
   typedef logic [`GB_IRQ_COUNT-1:0] irq_bits_t;

   // Sources in priority order
   // Lowest value wins when several are pending
   typedef enum logic [2:0] {
      IRQ_VBLANK = 3'd0,
      IRQ_LCDC   = 3'd1,
      IRQ_TIMA   = 3'd2,
      IRQ_SERIAL = 3'd3,
      IRQ_HILO   = 3'd4
   } irq_source_t;

   // Vector handshake towards the core
   typedef enum logic [1:0] {
      DISP_IDLE    = 2'd0,
      DISP_REQ     = 2'd1,
      DISP_RELEASE = 2'd2
   } dispatch_state_t;

   // Restart address as seen by the core
   typedef logic [7:0] vector_t;

endpackage

// ==== design/irq_status_if.sv ====
`timescale 1ns/100ps

interface irq_status_if;
   import gb_irq_pkg::*;

   // Flag state, from the flag registers
   irq_bits_t if_bits;
   irq_bits_t ie_bits;
   logic ime;

   // Accepted source, from the priority stage
   // Removes the bit from IF and drops IME
   logic clear;
   irq_source_t clear_source;

   // Register side
   modport flags (
      output if_bits,
      output ie_bits,
      output ime,
      input  clear,
      input  clear_source
   );

   // Priority side
   modport select (
      input  if_bits,
      input  ie_bits,
      input  ime,
      output clear,
      output clear_source
   );

endinterface

// ==== design/irq_flag_regs.sv ====
`timescale 1ns/100ps

module irq_flag_regs (
   input  logic                  clock,
   input  logic                  reset,
   input  gb_irq_pkg::irq_bits_t if_in,
   input  logic                  if_load,
   input  gb_irq_pkg::irq_bits_t ie_in,
   input  logic                  ie_load,
   input  logic                  ime_set,
   input  logic                  ime_reset,
   irq_status_if.flags           status,
   output gb_irq_pkg::irq_bits_t if_data,
   output gb_irq_pkg::irq_bits_t ie_data,
   output logic                  ime
);
   import gb_irq_pkg::*;

   // Interrupt flag, interrupt enable, master enable
   irq_bits_t if_q;
   irq_bits_t ie_q;
   logic ime_q;

   // Next-state terms
   irq_bits_t clear_mask;
   irq_bits_t if_next;
   logic ime_next;

   // All ones except the accepted source
   assign clear_mask = status.clear ? ~(irq_bits_t'(1) << status.clear_source) : '1;

   always_comb begin
      if (status.clear) begin
         // Request bits arriving with a clear are merged, not lost
         if_next = (if_load ? if_in : '0) | (if_q & clear_mask);
      end else if (if_load) begin
         if_next = if_in;
      end else begin
         if_next = if_q;
      end
   end

   always_comb begin
      // Set beats both reset and the clear from a capture
      if (ime_set) begin
         ime_next = 1'b1;
      end else if (ime_reset || status.clear) begin
         ime_next = 1'b0;
      end else begin
         ime_next = ime_q;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q  <= '0;
         ie_q  <= '0;
         // Master enable comes up on
         ime_q <= 1'b1;
      end else begin
         if_q  <= if_next;
         ime_q <= ime_next;
         if (ie_load) begin
            ie_q <= ie_in;
         end
      end
   end

   // State towards the priority stage
   assign status.if_bits = if_q;
   assign status.ie_bits = ie_q;
   assign status.ime     = ime_q;

   // Visible copies at the top level
   assign if_data = if_q;
   assign ie_data = ie_q;
   assign ime     = ime_q;

   // Priority must only accept a source that is really flagged
   a_clear_flagged : assert property (
      @(posedge clock) disable iff (reset)
      status.clear |-> if_q[status.clear_source]
   ) else $error("clear names source %0d whose IF bit is not set",
                 status.clear_source);

endmodule

// ==== design/irq_priority.sv ====
`timescale 1ns/100ps
`include "gb_irq_cfg.svh"

module irq_priority (
   input  logic                    clock,
   input  logic                    reset,
   irq_status_if.select            status,
   input  logic                    cap_ack,
   output logic                    cap_req,
   output gb_irq_pkg::irq_source_t cap_source
);
   import gb_irq_pkg::*;

   // Enabled and flagged sources
   irq_bits_t pending;
   // Lowest pending source
   irq_source_t sel;
   // Take a source this cycle
   logic capture;

   assign pending = status.if_bits & status.ie_bits;

   // Fixed priority, lowest index wins
   // Scan downwards so the last hit is the lowest bit
   always_comb begin
      sel = IRQ_VBLANK;
      for (int i = `GB_IRQ_COUNT - 1; i >= 0; i--) begin
         if (pending[i]) begin
            sel = irq_source_t'(3'(i));
         end
      end
   end

   // Idle means both halves of the last cap handshake are done
   // IME gates everything, as in the core
   assign capture = status.ime && (|pending) && !cap_req && !cap_ack;

   // Clear is a one-cycle pulse in the capture cycle
   // Flag regs drop the IF bit and IME on the same edge
   assign status.clear        = capture;
   assign status.clear_source = sel;

   // Request side of the cap handshake
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         cap_req <= 1'b0;
      end else if (capture) begin
         cap_req <= 1'b1;
      end else if (cap_ack) begin
         // Dispatch has the source, let go
         cap_req <= 1'b0;
      end
   end

   // Holding register for the captured source
   // Only written when idle, so steady during cap_req
   always_ff @(posedge clock) begin
      if (capture) begin
         cap_source <= sel;
      end
   end

   // Dispatch samples cap_source at any point while cap_req is up
   a_cap_source_stable : assert property (
      @(posedge clock) disable iff (reset)
      cap_req && $past(cap_req) |-> cap_source == $past(cap_source)
   ) else $error("cap_source changed while cap_req was high");

endmodule

// ==== design/irq_dispatch.sv ====
`timescale 1ns/100ps
`include "gb_irq_cfg.svh"

module irq_dispatch (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    cap_req,
   input  gb_irq_pkg::irq_source_t cap_source,
   input  logic                    vector_ack,
   output logic                    cap_ack,
   output logic                    vector_req,
   output gb_irq_pkg::vector_t     vector
);
   import gb_irq_pkg::*;

   dispatch_state_t state;
   // Source being offered to the core
   irq_source_t held_source;
   // Accept a new source from priority
   logic take;

   // Only one source held at a time
   // Ack from the previous vector already dropped in DISP_RELEASE
   assign take = (state == DISP_IDLE) && cap_req && !cap_ack;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= DISP_IDLE;
      end else begin
         case (state)
            DISP_IDLE: begin
               if (take) begin
                  state <= DISP_REQ;
               end
            end
            DISP_REQ: begin
               // Wait for the core to take the vector
               if (vector_ack) begin
                  state <= DISP_RELEASE;
               end
            end
            DISP_RELEASE: begin
               // Request is down, wait for ack to follow
               if (!vector_ack) begin
                  state <= DISP_IDLE;
               end
            end
            default: begin
               state <= DISP_IDLE;
            end
         endcase
      end
   end

   // Ack side of the cap handshake
   // Runs on its own so priority can refill while the core is slow
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         cap_ack <= 1'b0;
      end else if (!cap_req) begin
         cap_ack <= 1'b0;
      end else if (take) begin
         cap_ack <= 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (take) begin
         held_source <= cap_source;
      end
   end

   assign vector_req = (state == DISP_REQ);

   // Restart address, base plus step per source
   assign vector = `GB_IRQ_VECTOR_BASE + (`GB_IRQ_VECTOR_STEP * vector_t'(held_source));

   // Core may sample vector anywhere in the request window
   a_vector_stable : assert property (
      @(posedge clock) disable iff (reset)
      vector_req && $past(vector_req) |-> vector == $past(vector)
   ) else $error("vector changed while vector_req was high");

   // Previous handshake must be fully closed
   a_req_after_ack_low : assert property (
      @(posedge clock) disable iff (reset)
      $rose(vector_req) |-> !$past(vector_ack)
   ) else $error("vector_req rose while vector_ack was still high");

endmodule

// ==== design/gb_irq_unit.sv ====
`timescale 1ns/100ps
`include "gb_irq_cfg.svh"

module gb_irq_unit (
   input  logic                     clock,
   input  logic                     reset,
   input  logic [`GB_IRQ_COUNT-1:0] if_in,
   input  logic                     if_load,
   input  logic [`GB_IRQ_COUNT-1:0] ie_in,
   input  logic                     ie_load,
   input  logic                     ime_set,
   input  logic                     ime_reset,
   input  logic                     vector_ack,
   output logic                     vector_req,
   output logic [7:0]               vector,
   output logic [`GB_IRQ_COUNT-1:0] if_data,
   output logic [`GB_IRQ_COUNT-1:0] ie_data,
   output logic                     ime
);
   import gb_irq_pkg::*;

   // Flag state out, clear back
   irq_status_if status ();

   // Priority to dispatch handshake
   logic cap_req;
   logic cap_ack;
   irq_source_t cap_source;

   // Stage 1, IF, IE and IME
   irq_flag_regs i_flag_regs (
      .clock     (clock),
      .reset     (reset),
      .if_in     (if_in),
      .if_load   (if_load),
      .ie_in     (ie_in),
      .ie_load   (ie_load),
      .ime_set   (ime_set),
      .ime_reset (ime_reset),
      .status    (status.flags),
      .if_data   (if_data),
      .ie_data   (ie_data),
      .ime       (ime)
   );

   // Stage 2, select and capture
   irq_priority i_priority (
      .clock      (clock),
      .reset      (reset),
      .status     (status.select),
      .cap_ack    (cap_ack),
      .cap_req    (cap_req),
      .cap_source (cap_source)
   );

   // Stage 3, vector towards the core
   irq_dispatch i_dispatch (
      .clock      (clock),
      .reset      (reset),
      .cap_req    (cap_req),
      .cap_source (cap_source),
      .vector_ack (vector_ack),
      .cap_ack    (cap_ack),
      .vector_req (vector_req),
      .vector     (vector)
   );

endmodule

// ==== testbench/irq_checker.sv ====
`timescale 1ns/100ps
`include "gb_irq_cfg.svh"

module irq_checker (
   input  logic                     clock,
   input  logic                     reset,
   input  logic [`GB_IRQ_COUNT-1:0] if_in,
   input  logic                     if_load,
   input  logic [`GB_IRQ_COUNT-1:0] ie_in,
   input  logic                     ie_load,
   input  logic                     ime_set,
   input  logic                     ime_reset,
   input  logic                     vector_ack,
   input  logic                     vector_req,
   input  logic [7:0]               vector,
   input  logic [`GB_IRQ_COUNT-1:0] if_data,
   input  logic [`GB_IRQ_COUNT-1:0] ie_data,
   input  logic                     ime,
   output logic                     idle,
   output int                       error_count
);
   typedef logic [`GB_IRQ_COUNT-1:0] bits_t;

   // Restart address of VBLANK and spacing per source
   localparam logic [7:0] FIRST_VECTOR = 8'h40;
   localparam int VECTOR_SPACING = 8;

   // Flag model, state after the last edge
   bits_t m_if = '0;
   bits_t m_ie = '0;
   logic m_ime = 1'b1;
   // Inputs and handshake half a cycle before that edge
   bits_t p_if_in;
   bits_t p_ie_in;
   logic p_if_load;
   logic p_ie_load;
   logic p_ime_set;
   logic p_ime_reset;
   logic p_req = 1'b0;
   logic p_ack = 1'b0;
   logic [7:0] p_vector;
   // Captured sources still owed a vector, oldest first
   int expected[$];
   int flag_errors = 0;
   int vector_errors = 0;
   int handshake_errors = 0;
   int served = 0;

   function automatic int lowest_set(input bits_t bits);
      int index;
      index = -1;
      for (int i = 0; i < `GB_IRQ_COUNT; i++) begin
         if (bits[i] && index < 0) begin
            index = i;
         end
      end
      return index;
   endfunction

   task print_counts();
      $display("errors: flags %0d, vectors %0d, handshake %0d (vectors served %0d)",
               flag_errors, vector_errors, handshake_errors, served);
   endtask

   always @(negedge clock) begin
      bits_t taken;
      logic capture;
      logic [7:0] want;
      int source;
      if (reset) begin
         if (vector_req !== 1'b0 || if_data !== '0 || ie_data !== '0 || ime !== 1'b1) begin
            $display("error at %0d ns: outputs not at reset values", $time);
            flag_errors++;
         end
         m_if = '0;
         m_ie = '0;
         m_ime = 1'b1;
         expected.delete();
      end else begin
         source = lowest_set(m_if & m_ie);
         taken = (source < 0) ? '0 : bits_t'(1) << source;
         // A forced IME hides the capture, IF still shows the dropped bit
         if (p_ime_set || p_ime_reset) begin
            capture = m_ime && source >= 0 && !p_if_load && if_data == (m_if & ~taken);
         end else begin
            capture = m_ime && !ime;
         end
         if (capture && source < 0) begin
            $display("error at %0d ns: IME dropped with nothing pending", $time);
            flag_errors++;
            capture = 1'b0;
         end
         if (capture) begin
            m_if = (p_if_load ? p_if_in : '0) | (m_if & ~taken);
            expected.push_back(source);
         end else if (p_if_load) begin
            m_if = p_if_in;
         end
         if (p_ie_load) begin
            m_ie = p_ie_in;
         end
         if (p_ime_set) begin
            m_ime = 1'b1;
         end else if (p_ime_reset || capture) begin
            m_ime = 1'b0;
         end
         if (if_data !== m_if || ie_data !== m_ie || ime !== m_ime) begin
            $display("error at %0d ns: IF %h IE %h IME %b, expected %h %h %b",
                     $time, if_data, ie_data, ime, m_if, m_ie, m_ime);
            flag_errors++;
            // Follow the DUT so one slip is not counted every cycle
            m_if = if_data;
            m_ie = ie_data;
            m_ime = ime;
         end
         // New vector, previous handshake must be closed
         if (vector_req && !p_req) begin
            if (p_ack) begin
               $display("error at %0d ns: vector_req rose with vector_ack high", $time);
               handshake_errors++;
            end
            if (expected.size() == 0) begin
               $display("error at %0d ns: vector_req with no capture, IME %b", $time, ime);
               handshake_errors++;
            end else begin
               source = expected.pop_front();
               served++;
               want = FIRST_VECTOR + 8'(VECTOR_SPACING * source);
               if (vector !== want) begin
                  $display("error at %0d ns: vector %h, expected %h for source %0d",
                           $time, vector, want, source);
                  vector_errors++;
               end
            end
         end
         if (vector_req && p_req && vector !== p_vector) begin
            $display("error at %0d ns: vector moved from %h to %h", $time, p_vector, vector);
            handshake_errors++;
         end
         if (!vector_req && p_req && !p_ack) begin
            $display("error at %0d ns: vector_req fell without vector_ack", $time);
            handshake_errors++;
         end
      end
      p_if_in = if_in;
      p_if_load = if_load;
      p_ie_in = ie_in;
      p_ie_load = ie_load;
      p_ime_set = ime_set;
      p_ime_reset = ime_reset;
      p_req = vector_req;
      p_ack = vector_ack;
      p_vector = vector;
      idle = expected.size() == 0;
      error_count = flag_errors + vector_errors + handshake_errors;
   end

endmodule

// ==== testbench/tb_gb_irq_unit.sv ====
`timescale 1ns/100ps
`include "gb_irq_cfg.svh"

module tb_gb_irq_unit;
   typedef logic [`GB_IRQ_COUNT-1:0] bits_t;

   localparam int CLOCK_PERIOD = 8;
   localparam int TEST_CYCLES = 3000;
   // Longest ack delay plus both handshakes, in cycles
   localparam int WORST_HANDSHAKE = 12;

   logic clock = 1'b0;
   logic reset = 1'b1;
   bits_t if_in = '0;
   logic if_load = 1'b0;
   bits_t ie_in = '0;
   logic ie_load = 1'b0;
   logic ime_set = 1'b0;
   logic ime_reset = 1'b0;
   logic vector_ack = 1'b0;
   logic vector_req;
   logic [7:0] vector;
   bits_t if_data;
   bits_t ie_data;
   logic ime;
   logic checker_idle;
   int error_count;

   int seed = 32'h49ad;
   // Core wait before ack, cycles
   int ack_delay = 2;
   bit running = 1'b1;

   gb_irq_unit i_dut (
      .clock      (clock),
      .reset      (reset),
      .if_in      (if_in),
      .if_load    (if_load),
      .ie_in      (ie_in),
      .ie_load    (ie_load),
      .ime_set    (ime_set),
      .ime_reset  (ime_reset),
      .vector_ack (vector_ack),
      .vector_req (vector_req),
      .vector     (vector),
      .if_data    (if_data),
      .ie_data    (ie_data),
      .ime        (ime)
   );

   irq_checker i_checker (
      .clock       (clock),
      .reset       (reset),
      .if_in       (if_in),
      .if_load     (if_load),
      .ie_in       (ie_in),
      .ie_load     (ie_load),
      .ime_set     (ime_set),
      .ime_reset   (ime_reset),
      .vector_ack  (vector_ack),
      .vector_req  (vector_req),
      .vector      (vector),
      .if_data     (if_data),
      .ie_data     (ie_data),
      .ime         (ime),
      .idle        (checker_idle),
      .error_count (error_count)
   );

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   // Flag stimulus and core responder share one random stream
   always @(posedge clock) begin
      logic force_set;
      logic force_clear;
      if (reset || !running) begin
         // After the run IF and IE are emptied so the queue can drain
         if_in     <= '0;
         if_load   <= !reset;
         ie_in     <= '0;
         ie_load   <= !reset;
         ime_set   <= 1'b0;
         ime_reset <= 1'b0;
      end else begin
         force_set   = ($random(seed) & 7) == 0;
         force_clear = ($random(seed) & 15) == 0;
         ime_set   <= force_set;
         ime_reset <= force_clear;
         // No IF load beside an IME write, a capture then still shows in IF
         if_load <= !(force_set || force_clear) && (($random(seed) & 3) == 0);
         if_in   <= bits_t'($random(seed));
         ie_load <= ($random(seed) & 7) == 0;
         ie_in   <= bits_t'($random(seed));
      end
      if (reset) begin
         vector_ack <= 1'b0;
      end else if (vector_req && !vector_ack) begin
         if (ack_delay == 0) begin
            vector_ack <= 1'b1;
         end else begin
            ack_delay = ack_delay - 1;
         end
      end else if (!vector_req && vector_ack) begin
         vector_ack <= 1'b0;
         ack_delay = $random(seed) & 7;
      end
   end

   initial begin
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      repeat (TEST_CYCLES) @(posedge clock);
      @(negedge clock);
      running = 1'b0;
      // Last capture reaches the queue, then the core side empties it
      repeat (4) @(posedge clock);
      while (!checker_idle || vector_req || vector_ack) begin
         @(posedge clock);
      end
      i_checker.print_counts();
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TEST_CYCLES * WORST_HANDSHAKE * CLOCK_PERIOD);
      $display("Timeout: captured requests were still not served after %0d ns", $time);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== gb_irq_unit.f ====
+incdir+design
design/gb_irq_pkg.sv
design/irq_status_if.sv
design/irq_flag_regs.sv
design/irq_priority.sv
design/irq_dispatch.sv
design/gb_irq_unit.sv
testbench/irq_checker.sv
testbench/tb_gb_irq_unit.sv

// ==== Makefile ====
TOP := tb_gb_irq_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f gb_irq_unit.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf obj_dir
